//--- design/cache_controller.sv
`timescale 1ns/10ps

module cache_controller (
    // from memory
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] mem2proc_response,  // zero means refused
    input  logic [mem_pkg::BLOCK_BITS-1:0]   mem2proc_data,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] mem2proc_tag,
    // to memory
    output mem_pkg::bus_cmd_e                proc2mem_command,
    output logic [mem_pkg::XLEN-1:0]         proc2mem_addr,
    output logic [mem_pkg::BLOCK_BITS-1:0]   proc2Dmem_data,
    // instruction cache side
    input  mem_pkg::bus_cmd_e                Icache2ctrl_command,
    input  logic [mem_pkg::XLEN-1:0]         Icache2ctrl_addr,
    output logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Icache_response,
    output logic [mem_pkg::BLOCK_BITS-1:0]   ctrl2Icache_data,
    output logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Icache_tag,
    // data cache side
    input  mem_pkg::bus_cmd_e                Dcache2ctrl_command,
    input  logic [mem_pkg::XLEN-1:0]         Dcache2ctrl_addr,
    input  logic [mem_pkg::BLOCK_BITS-1:0]   Dcache2ctrl_data,
    output logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Dcache_response,
    output logic [mem_pkg::BLOCK_BITS-1:0]   ctrl2Dcache_data,
    output logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Dcache_tag
);
    import mem_pkg::*;

    logic d_wins;

    assign d_wins = (Dcache2ctrl_command != BUS_NONE);  // data side has priority

    always_comb begin
        if (d_wins) begin
            proc2mem_command     = Dcache2ctrl_command;
            proc2mem_addr        = Dcache2ctrl_addr;
            proc2Dmem_data       = Dcache2ctrl_data;
            ctrl2Dcache_response = mem2proc_response;
            ctrl2Icache_response = '0;
        end else begin
            proc2mem_command     = Icache2ctrl_command;
            proc2mem_addr        = Icache2ctrl_addr;
            proc2Dmem_data       = '0;  // fetches carry no data
            ctrl2Dcache_response = '0;
            ctrl2Icache_response = mem2proc_response;
        end
    end

    // returning data goes to both, each cache matches its own tag
    assign ctrl2Icache_data = mem2proc_data;
    assign ctrl2Icache_tag  = mem2proc_tag;
    assign ctrl2Dcache_data = mem2proc_data;
    assign ctrl2Dcache_tag  = mem2proc_tag;

endmodule

//--- design/dcache.sv
`timescale 1ns/10ps

module dcache (
    input  logic                             clock,
    input  logic                             rst,
    input  mem_pkg::bus_cmd_e                dc_cmd,
    input  logic [mem_pkg::XLEN-1:0]         dc_addr,
    input  logic [mem_pkg::BLOCK_BITS-1:0]   dc_wdata,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Dcache_response,
    input  logic [mem_pkg::BLOCK_BITS-1:0]   ctrl2Dcache_data,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Dcache_tag,
    output logic [mem_pkg::BLOCK_BITS-1:0]   dc_rdata,
    output logic                             dc_done,
    output mem_pkg::bus_cmd_e                Dcache2ctrl_command,
    output logic [mem_pkg::XLEN-1:0]         Dcache2ctrl_addr,
    output logic [mem_pkg::BLOCK_BITS-1:0]   Dcache2ctrl_data
);
    import mem_pkg::*;

    logic [TAG_BITS-1:0]    tags   [CACHE_LINES];
    logic [BLOCK_BITS-1:0]  blocks [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid;

    miss_state_e             state;
    logic [MEM_TAG_BITS-1:0] pend_tag;
    logic [XLEN-4:0]         miss_blk;

    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] miss_idx;
    logic                hit;
    logic                load_miss;
    logic                store_req;
    logic                store_ack;
    logic                accepted;
    logic                fill;

    assign idx      = dc_addr[IDX_BITS+OFFSET_BITS-1:OFFSET_BITS];
    assign tag      = dc_addr[XLEN-1:IDX_BITS+OFFSET_BITS];
    assign hit      = valid[idx] && (tags[idx] == tag);
    assign miss_idx = miss_blk[IDX_BITS-1:0];

    // stores bypass the miss FSM and go straight out
    assign load_miss = (state == MS_IDLE) && (dc_cmd == BUS_LOAD) && !hit;
    assign store_req = (state == MS_IDLE) && (dc_cmd == BUS_STORE);
    assign store_ack = store_req && (ctrl2Dcache_response != '0);
    assign accepted  = (state == MS_REQ) && (ctrl2Dcache_response != '0);
    assign fill      = (state == MS_WAIT) && (ctrl2Dcache_tag == pend_tag);

    assign dc_rdata = blocks[idx];
    assign dc_done  = ((state == MS_IDLE) && (dc_cmd == BUS_LOAD) && hit) || store_ack;

    always_comb begin
        Dcache2ctrl_command = BUS_NONE;
        Dcache2ctrl_addr    = {miss_blk, {OFFSET_BITS{1'b0}}};
        if (state == MS_REQ) begin
            Dcache2ctrl_command = BUS_LOAD;
        end else if (store_req) begin
            Dcache2ctrl_command = BUS_STORE;
            Dcache2ctrl_addr    = {dc_addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
    end

    assign Dcache2ctrl_data = dc_wdata;

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= MS_IDLE;
            pend_tag <= '0;
            valid    <= '0;
        end else begin
            case (state)
                MS_IDLE: begin
                    if (load_miss)
                        state <= MS_REQ;
                end
                MS_REQ: begin
                    if (accepted) begin
                        state    <= MS_WAIT;
                        pend_tag <= ctrl2Dcache_response;
                    end
                end
                MS_WAIT: begin
                    if (fill) begin
                        state           <= MS_IDLE;
                        valid[miss_idx] <= 1'b1;
                    end
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    // line writes: refill from memory or store hit
    always_ff @(posedge clock) begin
        if (state == MS_IDLE)
            miss_blk <= dc_addr[XLEN-1:OFFSET_BITS];
        if (fill) begin
            tags[miss_idx]   <= miss_blk[XLEN-4:IDX_BITS];
            blocks[miss_idx] <= ctrl2Dcache_data;
        end else if (store_ack && hit) begin
            blocks[idx] <= dc_wdata;  // no allocate on a store miss
        end
    end

endmodule

//--- design/icache.sv
`timescale 1ns/10ps

module icache (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             if_req,
    input  logic [mem_pkg::XLEN-1:0]         if_addr,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Icache_response,
    input  logic [mem_pkg::BLOCK_BITS-1:0]   ctrl2Icache_data,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Icache_tag,
    output logic [mem_pkg::BLOCK_BITS-1:0]   if_data,
    output logic                             if_valid,
    output mem_pkg::bus_cmd_e                Icache2ctrl_command,
    output logic [mem_pkg::XLEN-1:0]         Icache2ctrl_addr
);
    import mem_pkg::*;

    logic [TAG_BITS-1:0]    tags   [CACHE_LINES];
    logic [BLOCK_BITS-1:0]  blocks [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid;

    miss_state_e             state;
    logic [MEM_TAG_BITS-1:0] pend_tag;
    logic [XLEN-4:0]         miss_blk;  // block address of the miss

    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] miss_idx;
    logic                hit;
    logic                accepted;
    logic                fill;

    assign idx      = if_addr[IDX_BITS+OFFSET_BITS-1:OFFSET_BITS];
    assign tag      = if_addr[XLEN-1:IDX_BITS+OFFSET_BITS];
    assign hit      = valid[idx] && (tags[idx] == tag);
    assign miss_idx = miss_blk[IDX_BITS-1:0];

    assign accepted = (state == MS_REQ) && (ctrl2Icache_response != '0);
    assign fill     = (state == MS_WAIT) && (ctrl2Icache_tag == pend_tag);

    // lookup side
    assign if_data  = blocks[idx];
    assign if_valid = if_req && hit && (state == MS_IDLE);

    // bus side
    assign Icache2ctrl_command = (state == MS_REQ) ? BUS_LOAD : BUS_NONE;
    assign Icache2ctrl_addr    = {miss_blk, {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= MS_IDLE;
            pend_tag <= '0;
            valid    <= '0;
        end else begin
            case (state)
                MS_IDLE: begin
                    if (if_req && !hit)
                        state <= MS_REQ;
                end
                MS_REQ: begin
                    if (accepted) begin
                        state    <= MS_WAIT;
                        pend_tag <= ctrl2Icache_response;  // tag to watch for
                    end
                end
                MS_WAIT: begin
                    if (fill) begin
                        state           <= MS_IDLE;
                        valid[miss_idx] <= 1'b1;
                    end
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == MS_IDLE)
            miss_blk <= if_addr[XLEN-1:OFFSET_BITS];  // latched on the miss edge
        if (fill) begin
            tags[miss_idx]   <= miss_blk[XLEN-4:IDX_BITS];
            blocks[miss_idx] <= ctrl2Icache_data;
        end
    end

endmodule

//--- design/mem_pkg.sv
package mem_pkg;

    // address and block geometry
    localparam int XLEN         = 32;
    localparam int BLOCK_BITS   = 64;  // one doubleword per block
    localparam int CACHE_LINES  = 32;
    localparam int IDX_BITS     = 5;
    localparam int OFFSET_BITS  = 3;   // byte offset inside a block
    localparam int TAG_BITS     = XLEN - IDX_BITS - OFFSET_BITS;

    // width of the memory response number and the returned tag
    localparam int MEM_TAG_BITS = 4;

    // memory bus commands
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_cmd_e;

    // miss handling in both caches
    typedef enum logic [1:0] {
        MS_IDLE = 2'h0,  // no miss outstanding
        MS_REQ  = 2'h1,  // asking the bus until accepted
        MS_WAIT = 2'h2   // accepted, waiting for the tag to come back
    } miss_state_e;

endpackage

//--- design/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem (
    input  logic                             clock,
    input  logic                             rst,
    // fetch port
    input  logic                             if_req,
    input  logic [mem_pkg::XLEN-1:0]         if_addr,
    output logic [mem_pkg::BLOCK_BITS-1:0]   if_data,
    output logic                             if_valid,
    // data port
    input  mem_pkg::bus_cmd_e                dc_cmd,
    input  logic [mem_pkg::XLEN-1:0]         dc_addr,
    input  logic [mem_pkg::BLOCK_BITS-1:0]   dc_wdata,
    output logic [mem_pkg::BLOCK_BITS-1:0]   dc_rdata,
    output logic                             dc_done,
    // memory bus
    output mem_pkg::bus_cmd_e                proc2mem_command,
    output logic [mem_pkg::XLEN-1:0]         proc2mem_addr,
    output logic [mem_pkg::BLOCK_BITS-1:0]   proc2Dmem_data,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] mem2proc_response,
    input  logic [mem_pkg::BLOCK_BITS-1:0]   mem2proc_data,
    input  logic [mem_pkg::MEM_TAG_BITS-1:0] mem2proc_tag
);
    import mem_pkg::*;

    bus_cmd_e                Icache2ctrl_command;
    logic [XLEN-1:0]         Icache2ctrl_addr;
    logic [MEM_TAG_BITS-1:0] ctrl2Icache_response;
    logic [BLOCK_BITS-1:0]   ctrl2Icache_data;
    logic [MEM_TAG_BITS-1:0] ctrl2Icache_tag;

    bus_cmd_e                Dcache2ctrl_command;
    logic [XLEN-1:0]         Dcache2ctrl_addr;
    logic [BLOCK_BITS-1:0]   Dcache2ctrl_data;
    logic [MEM_TAG_BITS-1:0] ctrl2Dcache_response;
    logic [BLOCK_BITS-1:0]   ctrl2Dcache_data;
    logic [MEM_TAG_BITS-1:0] ctrl2Dcache_tag;

    icache u_icache (
        .clock(clock), .rst(rst),
        .if_req(if_req), .if_addr(if_addr),
        .ctrl2Icache_response(ctrl2Icache_response),
        .ctrl2Icache_data(ctrl2Icache_data), .ctrl2Icache_tag(ctrl2Icache_tag),
        .if_data(if_data), .if_valid(if_valid),
        .Icache2ctrl_command(Icache2ctrl_command), .Icache2ctrl_addr(Icache2ctrl_addr)
    );

    dcache u_dcache (
        .clock(clock), .rst(rst),
        .dc_cmd(dc_cmd), .dc_addr(dc_addr), .dc_wdata(dc_wdata),
        .ctrl2Dcache_response(ctrl2Dcache_response),
        .ctrl2Dcache_data(ctrl2Dcache_data), .ctrl2Dcache_tag(ctrl2Dcache_tag),
        .dc_rdata(dc_rdata), .dc_done(dc_done),
        .Dcache2ctrl_command(Dcache2ctrl_command), .Dcache2ctrl_addr(Dcache2ctrl_addr),
        .Dcache2ctrl_data(Dcache2ctrl_data)
    );

    cache_controller u_cache_controller (
        .mem2proc_response(mem2proc_response), .mem2proc_data(mem2proc_data),
        .mem2proc_tag(mem2proc_tag),
        .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
        .proc2Dmem_data(proc2Dmem_data),
        .Icache2ctrl_command(Icache2ctrl_command), .Icache2ctrl_addr(Icache2ctrl_addr),
        .ctrl2Icache_response(ctrl2Icache_response),
        .ctrl2Icache_data(ctrl2Icache_data), .ctrl2Icache_tag(ctrl2Icache_tag),
        .Dcache2ctrl_command(Dcache2ctrl_command), .Dcache2ctrl_addr(Dcache2ctrl_addr),
        .Dcache2ctrl_data(Dcache2ctrl_data),
        .ctrl2Dcache_response(ctrl2Dcache_response),
        .ctrl2Dcache_data(ctrl2Dcache_data), .ctrl2Dcache_tag(ctrl2Dcache_tag)
    );

endmodule

//--- test/mem_model.sv
`timescale 1ns/10ps

module mem_model (
    input  logic                             clock,
    input  logic                             rst,
    input  mem_pkg::bus_cmd_e                proc2mem_command,
    input  logic [mem_pkg::XLEN-1:0]         proc2mem_addr,
    input  logic [mem_pkg::BLOCK_BITS-1:0]   proc2Dmem_data,
    output logic [mem_pkg::MEM_TAG_BITS-1:0] mem2proc_response,
    output logic [mem_pkg::BLOCK_BITS-1:0]   mem2proc_data,
    output logic [mem_pkg::MEM_TAG_BITS-1:0] mem2proc_tag
);
    import mem_pkg::*;

    localparam int MEM_LATENCY = 4;

    logic [31:0]             rnd;       // refusal source, low bit set means refuse
    logic [MEM_TAG_BITS-1:0] next_tag;
    logic [MEM_TAG_BITS-1:0] tag_pipe  [MEM_LATENCY];
    logic [BLOCK_BITS-1:0]   data_pipe [MEM_LATENCY];
    logic [XLEN-1:0]         st_addr [$];  // blocks written since reset
    logic [BLOCK_BITS-1:0]   st_data [$];

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched blocks read as their own address, inverted copy on top
    function automatic logic [BLOCK_BITS-1:0] read_block(input logic [XLEN-1:0] a);
        for (int i = 0; i < st_addr.size(); i++)
            if (st_addr[i] == a)
                return st_data[i];
        return {~a, a};
    endfunction

    task automatic write_block(input logic [XLEN-1:0] a, input logic [BLOCK_BITS-1:0] d);
        for (int i = 0; i < st_addr.size(); i++) begin
            if (st_addr[i] == a) begin
                st_data[i] = d;
                return;
            end
        end
        st_addr.push_back(a);
        st_data.push_back(d);
    endtask

    assign mem2proc_response = ((proc2mem_command != BUS_NONE) && !rnd[0]) ? next_tag : '0;
    assign mem2proc_tag      = tag_pipe[MEM_LATENCY-1];
    assign mem2proc_data     = data_pipe[MEM_LATENCY-1];

    always @(posedge clock) begin
        if (rst) begin
            rnd      <= 32'd88511;
            next_tag <= 1;
            for (int i = 0; i < MEM_LATENCY; i++) begin
                tag_pipe[i]  <= '0;
                data_pipe[i] <= '0;
            end
        end else begin
            rnd <= xorshift(rnd);
            for (int i = MEM_LATENCY - 1; i > 0; i--) begin
                tag_pipe[i]  <= tag_pipe[i-1];
                data_pipe[i] <= data_pipe[i-1];
            end
            tag_pipe[0]  <= '0;  // tag zero carries nothing
            data_pipe[0] <= '0;
            if (mem2proc_response != '0) begin
                next_tag <= (next_tag == '1) ? 1 : next_tag + 1;  // skip zero on wrap
                if (proc2mem_command == BUS_LOAD) begin
                    tag_pipe[0]  <= mem2proc_response;
                    data_pipe[0] <= read_block({proc2mem_addr[XLEN-1:3], 3'b000});
                end else begin
                    write_block({proc2mem_addr[XLEN-1:3], 3'b000}, proc2Dmem_data);
                end
            end
        end
    end

endmodule

//--- test/mem_subsystem_assertions.sv
`timescale 1ns/10ps

module mem_subsystem_assertions (
    input logic                             clock,
    input logic                             rst,
    input mem_pkg::bus_cmd_e                Dcache2ctrl_command,
    input mem_pkg::bus_cmd_e                proc2mem_command,
    input logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Icache_response,
    input logic [mem_pkg::MEM_TAG_BITS-1:0] ctrl2Dcache_response
);
    import mem_pkg::*;

    int fail_count = 0;

    // only the arbitration winner sees an accepting response
    one_response: assert property (@(posedge clock) disable iff (rst)
        !((ctrl2Icache_response != '0) && (ctrl2Dcache_response != '0)))
        else begin
            fail_count++;
            $error("both caches see a nonzero response");
        end

    icache_loses: assert property (@(posedge clock) disable iff (rst)
        (Dcache2ctrl_command != BUS_NONE) |-> (ctrl2Icache_response == '0))
        else begin
            fail_count++;
            $error("instruction cache answered while the data cache holds the bus");
        end

    store_source: assert property (@(posedge clock) disable iff (rst)
        (proc2mem_command == BUS_STORE) |-> (Dcache2ctrl_command == BUS_STORE))
        else begin
            fail_count++;
            $error("store on the memory bus not driven by the data cache");
        end

endmodule

bind mem_subsystem mem_subsystem_assertions u_assertions (
    .clock(clock),
    .rst(rst),
    .Dcache2ctrl_command(Dcache2ctrl_command),
    .proc2mem_command(proc2mem_command),
    .ctrl2Icache_response(ctrl2Icache_response),
    .ctrl2Dcache_response(ctrl2Dcache_response)
);

//--- test/mem_subsystem_tb.sv
`timescale 1ns/10ps

module mem_subsystem_tb;
    import mem_pkg::*;

    localparam int NUM_ENTRIES = 16;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 40;

    logic                    clock;
    logic                    rst;
    logic                    if_req;
    logic [XLEN-1:0]         if_addr;
    logic [BLOCK_BITS-1:0]   if_data;
    logic                    if_valid;
    bus_cmd_e                dc_cmd;
    logic [XLEN-1:0]         dc_addr;
    logic [BLOCK_BITS-1:0]   dc_wdata;
    logic [BLOCK_BITS-1:0]   dc_rdata;
    logic                    dc_done;
    bus_cmd_e                proc2mem_command;
    logic [XLEN-1:0]         proc2mem_addr;
    logic [BLOCK_BITS-1:0]   proc2Dmem_data;
    logic [MEM_TAG_BITS-1:0] mem2proc_response;
    logic [BLOCK_BITS-1:0]   mem2proc_data;
    logic [MEM_TAG_BITS-1:0] mem2proc_tag;

    // stimulus table with one row per entry
    logic                  t_freq   [NUM_ENTRIES];
    logic [XLEN-1:0]       t_faddr  [NUM_ENTRIES];
    logic                  t_fhit   [NUM_ENTRIES];  // fetch must finish in its first cycle
    bus_cmd_e              t_dcmd   [NUM_ENTRIES];
    logic [XLEN-1:0]       t_daddr  [NUM_ENTRIES];
    logic [BLOCK_BITS-1:0] t_wdata  [NUM_ENTRIES];
    logic                  t_dhit   [NUM_ENTRIES];
    logic                  t_dfirst [NUM_ENTRIES];  // load must beat the fetch

    logic [XLEN-1:0]       shadow_addr [$];  // blocks stored so far
    logic [BLOCK_BITS-1:0] shadow_data [$];

    int cycle_count;
    int cur_entry;
    int errors;
    int passed;
    int assert_fails;

    mem_subsystem u_mem_subsystem (.*);
    mem_model     u_mem_model (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, entry %0d never completed",
                     cycle_count, cur_entry);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic set_entry(input int i, input logic fr, input logic [XLEN-1:0] fa,
                             input logic fh, input bus_cmd_e dc, input logic [XLEN-1:0] da,
                             input logic [BLOCK_BITS-1:0] wd, input logic dh, input logic df);
        t_freq[i]   = fr;
        t_faddr[i]  = fa;
        t_fhit[i]   = fh;
        t_dcmd[i]   = dc;
        t_daddr[i]  = da;
        t_wdata[i]  = wd;
        t_dhit[i]   = dh;
        t_dfirst[i] = df;
    endtask

    // content rule with stored blocks taking precedence
    function automatic logic [BLOCK_BITS-1:0] expected_block(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] ba;
        ba = {addr[XLEN-1:3], 3'b000};
        for (int i = 0; i < shadow_addr.size(); i++)
            if (shadow_addr[i] == ba)
                return shadow_data[i];
        return {~ba, ba};
    endfunction

    task automatic record_store(input logic [XLEN-1:0] addr, input logic [BLOCK_BITS-1:0] d);
        for (int i = 0; i < shadow_addr.size(); i++) begin
            if (shadow_addr[i] == {addr[XLEN-1:3], 3'b000}) begin
                shadow_data[i] = d;
                return;
            end
        end
        shadow_addr.push_back({addr[XLEN-1:3], 3'b000});
        shadow_data.push_back(d);
    endtask

    task automatic run_entry(input int n);
        logic                  f_busy;
        logic                  d_busy;
        int                    cyc;
        int                    f_cyc;
        int                    d_cyc;
        int                    bad;
        logic [BLOCK_BITS-1:0] f_exp;
        logic [BLOCK_BITS-1:0] d_exp;
        logic [BLOCK_BITS-1:0] f_got;
        logic [BLOCK_BITS-1:0] d_got;
        cur_entry = n;
        f_exp     = expected_block(t_faddr[n]);
        d_exp     = expected_block(t_daddr[n]);
        if_req    = t_freq[n];
        if_addr   = t_faddr[n];
        dc_cmd    = t_dcmd[n];
        dc_addr   = t_daddr[n];
        dc_wdata  = t_wdata[n];
        f_busy    = t_freq[n];
        d_busy    = (t_dcmd[n] != BUS_NONE);
        cyc       = 0;
        f_cyc     = 0;
        d_cyc     = 0;
        bad       = 0;
        while (f_busy || d_busy) begin
            @(negedge clock);  // outputs settled mid cycle
            cyc++;
            if (f_busy && if_valid) begin
                f_busy = 1'b0;
                f_cyc  = cyc;
                f_got  = if_data;
            end
            if (d_busy && dc_done) begin
                d_busy = 1'b0;
                d_cyc  = cyc;
                d_got  = dc_rdata;
            end
            @(posedge clock);
            #1;
            if (!f_busy)
                if_req = 1'b0;  // drop in the cycle after completion
            if (!d_busy)
                dc_cmd = BUS_NONE;
        end
        if (t_dcmd[n] == BUS_STORE)
            record_store(t_daddr[n], t_wdata[n]);
        if (t_freq[n] && f_got !== f_exp) begin
            $display("FAIL %0t: entry %0d fetch data %h, expected %h", $time, n, f_got, f_exp);
            bad++;
        end
        if (t_freq[n] && t_fhit[n] != (f_cyc == 1)) begin
            $display("FAIL %0t: entry %0d fetch took %0d cycles, expected a %s",
                     $time, n, f_cyc, t_fhit[n] ? "hit" : "miss");
            bad++;
        end
        if (t_dcmd[n] == BUS_LOAD && d_got !== d_exp) begin
            $display("FAIL %0t: entry %0d load data %h, expected %h", $time, n, d_got, d_exp);
            bad++;
        end
        if (t_dcmd[n] == BUS_LOAD && t_dhit[n] != (d_cyc == 1)) begin
            $display("FAIL %0t: entry %0d load took %0d cycles, expected a %s",
                     $time, n, d_cyc, t_dhit[n] ? "hit" : "miss");
            bad++;
        end
        if (t_dfirst[n] && d_cyc >= f_cyc) begin
            $display("FAIL %0t: entry %0d fetch done at cycle %0d, load only at %0d",
                     $time, n, f_cyc, d_cyc);
            bad++;
        end
        $display("entry %0d: %s (fetch %0d cycles, data %0d cycles)",
                 n, (bad == 0) ? "pass" : "fail", f_cyc, d_cyc);
        if (bad == 0)
            passed++;
        errors += bad;
    endtask

    initial begin
        clock        = 1'b0;
        rst          = 1'b1;
        if_req       = 1'b0;
        if_addr      = '0;
        dc_cmd       = BUS_NONE;
        dc_addr      = '0;
        dc_wdata     = '0;
        cycle_count  = 0;
        cur_entry    = -1;
        errors       = 0;
        passed       = 0;
        assert_fails = 0;
        // fetch miss then a hit in the same block
        set_entry(0,  1, 32'h1000, 0, BUS_NONE,  32'h0,    64'h0, 0, 0);
        set_entry(1,  1, 32'h1004, 1, BUS_NONE,  32'h0,    64'h0, 0, 0);
        set_entry(2,  0, 32'h0,    0, BUS_LOAD,  32'h2008, 64'h0, 0, 0);
        set_entry(3,  0, 32'h0,    0, BUS_LOAD,  32'h200c, 64'h0, 1, 0);
        // store hit updates the line but a store miss does not allocate
        set_entry(4,  0, 32'h0,    0, BUS_STORE, 32'h2008, 64'hdead_beef_0123_4567, 0, 0);
        set_entry(5,  0, 32'h0,    0, BUS_LOAD,  32'h2008, 64'h0, 1, 0);
        set_entry(6,  0, 32'h0,    0, BUS_STORE, 32'h3010, 64'h0bad_cafe_89ab_cdef, 0, 0);
        set_entry(7,  0, 32'h0,    0, BUS_LOAD,  32'h3010, 64'h0, 0, 0);
        set_entry(8,  1, 32'h1040, 0, BUS_LOAD,  32'h2040, 64'h0, 0, 1);
        // 0x4080 and 0x5080 share index 16
        set_entry(9,  1, 32'h4080, 0, BUS_LOAD,  32'h5080, 64'h0, 0, 1);
        set_entry(10, 1, 32'h5080, 0, BUS_LOAD,  32'h4080, 64'h0, 0, 0);
        set_entry(11, 1, 32'h4080, 0, BUS_LOAD,  32'h5080, 64'h0, 0, 0);
        set_entry(12, 1, 32'h4084, 1, BUS_LOAD,  32'h5084, 64'h0, 1, 0);
        set_entry(13, 1, 32'h1000, 1, BUS_STORE, 32'h6000, 64'h1357_9bdf_2468_ace0, 0, 0);
        set_entry(14, 0, 32'h0,    0, BUS_LOAD,  32'h6000, 64'h0, 0, 0);
        set_entry(15, 1, 32'h3010, 0, BUS_NONE,  32'h0,    64'h0, 0, 0);
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            run_entry(n);
            @(posedge clock);  // one idle cycle between entries
            #1;
        end
        assert_fails = u_mem_subsystem.u_assertions.fail_count;
        $display("entries %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 NUM_ENTRIES, passed, NUM_ENTRIES - passed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/mem_pkg.sv
design/icache.sv
design/dcache.sv
design/cache_controller.sv
design/mem_subsystem.sv
test/mem_model.sv
test/mem_subsystem_assertions.sv
test/mem_subsystem_tb.sv
